//--- hdl/lineRam.sv
// single port RAM, read before write, registered output
// one access per cen, so a read can clear the word in the same cycle
`timescale 1ns/1ns
`default_nettype none

module lineRam #(
    parameter int AW = 8,
    parameter int DW = 4
) (
    input  wire          clk,
    input  wire          cen,
    input  wire [AW-1:0] addr,
    input  wire [DW-1:0] data,
    input  wire          we,
    output logic [DW-1:0] q
);

    logic [DW-1:0] mem [0:(2**AW)-1];

    // power-up contents all ones: blank pixels, parked objects
    initial begin
        for (int i = 0; i < 2**AW; i++) begin
            mem[i] = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[addr];                 // old word out
            if (we) mem[addr] <= data;      // new word in
        end
    end

endmodule

`default_nettype wire

//--- hdl/objLine_cfg.svh
// object layer configuration
// slot count, attribute RAM depth, line buffer geometry and blank pixel code
`ifndef OBJLINE_CFG_SVH
`define OBJLINE_CFG_SVH

// attribute store
`define OBJ_COUNT 16            // object slots
`define OBJ_AW    4             // attribute address bits

// line buffer
`define PXL_DW    4             // bits per pixel
`define LINE_AW   8             // 256 visible columns

`define PXL_BLANK {`PXL_DW{1'b1}}   // transparent, also the cleared value

`define OBJ_WIDTH 16            // widest object, also the object height in lines

`endif

//--- hdl/objPkg.sv
// object layer types
// one attribute word, seen raw by host and RAM, decoded by the scanner
`default_nettype none
`include "objLine_cfg.svh"

package objPkg;

    typedef struct packed {
        logic [6:0]         unused;
        logic [3:0]         width;     // pixels minus one
        logic [`PXL_DW-1:0] colour;    // 15 = not drawn
        logic [7:0]         posY;      // first line covered
        logic [8:0]         posX;      // bit 8 set parks the object off screen
    } objFields_t;

    typedef union packed {
        logic [31:0] raw;
        objFields_t  fields;
    } objAttr_t;

endpackage

`default_nettype wire

//--- hdl/objPxlBuf.sv
// object line buffer, two RAMs swapping roles each line
// blank side takes scanner pixels, active side is read out and cleared behind
// flip mirrors the write column, colour 15 and x >= 256 are never stored
`timescale 1ns/1ns
`default_nettype none
`include "objLine_cfg.svh"

module objPxlBuf (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 pxlCen,
    input  wire                 lhbl,
    input  wire                 flip,
    input  wire                 dispEn,
    input  wire                 drawWe,
    input  wire [8:0]           drawX,
    input  wire [`PXL_DW-1:0]   drawPxl,
    output logic [`PXL_DW-1:0]  objPxl
);

    localparam logic [`PXL_DW-1:0] blank = `PXL_BLANK;

    logic                lineSel;   // RAM drawn in this blank, read next active
    logic                lhblLast;
    logic [`LINE_AW-1:0] hCnt;      // column being read
    logic                rdSide;
    logic                qSide;     // which RAM q came from
    logic                qLive;     // q is an active column
    logic [`LINE_AW-1:0] wrAddr;
    logic                wrWe;
    logic [`LINE_AW-1:0] addrA, addrB;
    logic [`PXL_DW-1:0]  dataA, dataB;
    logic                weA, weB;
    logic [`PXL_DW-1:0]  qA, qB;

    always_ff @(posedge clk) begin
        if (rst) begin
            lineSel  <= 1'b0;
            lhblLast <= 1'b0;
            hCnt     <= '0;
            qSide    <= 1'b0;
            qLive    <= 1'b0;
        end else if (pxlCen) begin
            lhblLast <= lhbl;
            if (lhblLast && !lhbl) lineSel <= !lineSel;   // swap on blank start
            hCnt  <= lhbl ? hCnt + 1'b1 : '0;
            qSide <= rdSide;
            qLive <= lhbl;
        end
    end

    // active: lineSel is read; blank: lineSel is drawn, the other side idles
    assign rdSide = lhbl ? lineSel : !lineSel;

    assign wrAddr = drawX[`LINE_AW-1:0] ^ {`LINE_AW{flip}};
    assign wrWe   = drawWe && !drawX[8] && (drawPxl != blank);

    always_comb begin
        if (!rdSide) begin
            addrA = hCnt;       // A read and cleared
            dataA = blank;
            weA   = lhbl;
            addrB = wrAddr;     // B drawn
            dataB = drawPxl;
            weB   = wrWe;
        end else begin
            addrA = wrAddr;
            dataA = drawPxl;
            weA   = wrWe;
            addrB = hCnt;
            dataB = blank;
            weB   = lhbl;
        end
    end

    assign objPxl = (dispEn && qLive) ? (qSide ? qB : qA) : blank;

    lineRam #(
        .AW ( `LINE_AW ),
        .DW ( `PXL_DW  )
    ) lineBufA (
        .clk  ( clk    ),
        .cen  ( pxlCen ),
        .addr ( addrA  ),
        .data ( dataA  ),
        .we   ( weA    ),
        .q    ( qA     )
    );

    lineRam #(
        .AW ( `LINE_AW ),
        .DW ( `PXL_DW  )
    ) lineBufB (
        .clk  ( clk    ),
        .cen  ( pxlCen ),
        .addr ( addrB  ),
        .data ( dataB  ),
        .we   ( weB    ),
        .q    ( qB     )
    );

endmodule

`default_nettype wire

//--- hdl/objRamArb.sv
// attribute RAM arbiter
// host writes always win, scanner reads wait for a free cycle
// read data comes back one clk after the grant and is held until the next one
`timescale 1ns/1ns
`default_nettype none
`include "objLine_cfg.svh"

module objRamArb (
    input  wire                  clk,
    input  wire                  rst,
    // host side, no back-pressure
    input  wire                  hostWe,
    input  wire [`OBJ_AW-1:0]    hostAddr,
    input  wire objPkg::objAttr_t hostData,
    // scanner side
    input  wire                  scanReq,
    input  wire [`OBJ_AW-1:0]    scanAddr,
    output logic                 scanGnt,
    output objPkg::objAttr_t     scanData
);

    localparam int attrW = $bits(objPkg::objAttr_t);

    logic [`OBJ_AW-1:0] ramAddr;
    logic               ramCen;
    logic [attrW-1:0]   ramQ;
    logic [attrW-1:0]   dataHold;   // last granted word
    logic               gntQ;       // q holds scanner data this cycle

    assign scanGnt = scanReq && !hostWe;    // host write blocks the read
    assign ramCen  = hostWe || scanGnt;     // idle port keeps q stable
    assign ramAddr = hostWe ? hostAddr : scanAddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            gntQ <= 1'b0;
        end else begin
            gntQ <= scanGnt;
        end
    end

    // keep the word after q moves on to a host access
    always_ff @(posedge clk) begin
        if (gntQ) dataHold <= ramQ;
    end

    assign scanData.raw = gntQ ? ramQ : dataHold;

    lineRam #(
        .AW ( `OBJ_AW ),
        .DW ( attrW   )
    ) attrRam (
        .clk  ( clk          ),
        .cen  ( ramCen       ),
        .addr ( ramAddr      ),
        .data ( hostData.raw ),
        .we   ( hostWe       ),
        .q    ( ramQ         )
    );

endmodule

`default_nettype wire

//--- hdl/objScan.sv
// object scanner
// on each blank start walks slots 15..0 for the coming line
// every visible object is emitted as colour pixels, one per pxlCen tick
// later slots overwrite earlier ones in the line buffer, so slot 0 ends on top
`timescale 1ns/1ns
`default_nettype none
`include "objLine_cfg.svh"

module objScan (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   pxlCen,
    input  wire                   lhbl,
    input  wire [7:0]             vDump,
    // attribute RAM through the arbiter
    output logic                  scanReq,
    output logic [`OBJ_AW-1:0]    scanAddr,
    input  wire                   scanGnt,
    input  wire objPkg::objAttr_t scanData,
    // pixels into the line buffer
    output logic                  drawWe,
    output logic [8:0]            drawX,
    output logic [`PXL_DW-1:0]    drawPxl,
    output logic                  scanBusy
);

    localparam logic [`PXL_DW-1:0] blank   = `PXL_BLANK;
    localparam logic [`OBJ_AW-1:0] topSlot = `OBJ_AW'(`OBJ_COUNT - 1);

    typedef enum logic [2:0] {
        stIdle,
        stReq,      // waiting for the grant
        stTest,     // scanData valid, decide on hit
        stDraw,     // emitting pixels
        stNext,
        stDone      // last pixel still to land
    } scanState_t;

    scanState_t         state;
    logic               lhblLast;
    logic [7:0]         lineNum;    // line being prepared
    logic [8:0]         posX;
    logic [`PXL_DW-1:0] colour;
    logic [3:0]         width;
    logic [3:0]         pxlCnt;
    logic [7:0]         dy;
    logic               visible;
    logic [8:0]         xSum;

    // hit test on the word straight from the arbiter
    assign dy      = lineNum - scanData.fields.posY;    // wraps for objects below
    assign visible = (dy < 8'(`OBJ_WIDTH))
                  && !scanData.fields.posX[8]           // parked
                  && (scanData.fields.colour != blank); // transparent object
    assign xSum    = posX + {5'd0, pxlCnt};             // posX < 256, no overflow

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= stIdle;
            lhblLast <= 1'b0;
            lineNum  <= 8'd0;
            scanReq  <= 1'b0;
            scanAddr <= '0;
            scanBusy <= 1'b0;
            drawWe   <= 1'b0;
            pxlCnt   <= 4'd0;
        end else begin
            if (pxlCen) begin
                lhblLast <= lhbl;
                drawWe   <= 1'b0;       // strobe lasts one tick
            end
            case (state)
                stIdle: begin
                    if (pxlCen && lhblLast && !lhbl) begin   // blank just started
                        lineNum  <= vDump + 8'd1;
                        scanAddr <= topSlot;
                        scanReq  <= 1'b1;
                        scanBusy <= 1'b1;
                        state    <= stReq;
                    end
                end
                stReq: begin
                    if (scanGnt) begin
                        scanReq <= 1'b0;    // data arrives next cycle
                        state   <= stTest;
                    end
                end
                stTest: begin
                    if (visible) begin
                        posX   <= scanData.fields.posX;
                        colour <= scanData.fields.colour;
                        width  <= scanData.fields.width;
                        pxlCnt <= 4'd0;
                        state  <= stDraw;
                    end else begin
                        state <= stNext;
                    end
                end
                stDraw: begin
                    if (pxlCen) begin
                        drawWe  <= !xSum[8];    // clip past column 255
                        drawX   <= xSum;
                        drawPxl <= colour;
                        pxlCnt  <= pxlCnt + 4'd1;
                        if (pxlCnt == width) state <= stNext;
                    end
                end
                stNext: begin
                    if (scanAddr == '0) begin
                        state <= stDone;
                    end else begin
                        scanAddr <= scanAddr - 1'b1;
                        scanReq  <= 1'b1;
                        state    <= stReq;
                    end
                end
                stDone: begin
                    // the buffer takes the final pixel on this tick
                    if (pxlCen) begin
                        scanBusy <= 1'b0;
                        state    <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/objSystem.sv
// object layer top
// attribute arbiter, line scanner and double line buffer
`timescale 1ns/1ns
`default_nettype none
`include "objLine_cfg.svh"

module objSystem (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   pxlCen,
    input  wire                   lhbl,
    input  wire [7:0]             vDump,
    input  wire                   flip,
    input  wire                   dispEn,
    input  wire                   hostWe,
    input  wire [`OBJ_AW-1:0]     hostAddr,
    input  wire objPkg::objAttr_t hostData,
    output logic [`PXL_DW-1:0]    objPxl,
    output logic                  scanBusy
);

    // scanner to arbiter
    logic                 scanReq;
    logic [`OBJ_AW-1:0]   scanAddr;
    logic                 scanGnt;
    objPkg::objAttr_t     scanData;
    // scanner to line buffer
    logic                 drawWe;
    logic [8:0]           drawX;
    logic [`PXL_DW-1:0]   drawPxl;

    objRamArb objRamArb_inst (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .hostWe   ( hostWe   ),
        .hostAddr ( hostAddr ),
        .hostData ( hostData ),
        .scanReq  ( scanReq  ),
        .scanAddr ( scanAddr ),
        .scanGnt  ( scanGnt  ),
        .scanData ( scanData )
    );

    objScan objScan_inst (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxlCen   ( pxlCen   ),
        .lhbl     ( lhbl     ),
        .vDump    ( vDump    ),
        .scanReq  ( scanReq  ),
        .scanAddr ( scanAddr ),
        .scanGnt  ( scanGnt  ),
        .scanData ( scanData ),
        .drawWe   ( drawWe   ),
        .drawX    ( drawX    ),
        .drawPxl  ( drawPxl  ),
        .scanBusy ( scanBusy )
    );

    objPxlBuf objPxlBuf_inst (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .pxlCen  ( pxlCen  ),
        .lhbl    ( lhbl    ),
        .flip    ( flip    ),
        .dispEn  ( dispEn  ),
        .drawWe  ( drawWe  ),
        .drawX   ( drawX   ),
        .drawPxl ( drawPxl ),
        .objPxl  ( objPxl  )
    );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the object layer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module objSystem_tb \
    -Mdir "$BUILD_DIR" -o objSystem_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/objSystem_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
    exit 0
fi
exit 1

//--- tb.f
+incdir+hdl
hdl/objPkg.sv
hdl/lineRam.sv
hdl/objRamArb.sv
hdl/objScan.sv
hdl/objPxlBuf.sv
hdl/objSystem.sv
tests/objSystem_tb.sv

//--- tests/objSystem_tb.sv
// object layer testbench
// drives line timing and attribute writes and checks objPxl against a line model
`timescale 1ns/1ns
`default_nettype none
`include "objLine_cfg.svh"

module objSystem_tb;

    localparam int numLines    = 10;
    localparam int activeTicks = 256;
    localparam int blankTicks  = 300;
    localparam int cycleLimit  = numLines * (activeTicks + blankTicks) * 4 + 200;
    localparam logic [`PXL_DW-1:0] blank = `PXL_BLANK;

    logic clk = 1'b0;
    logic rst, pxlCen, lhbl, flip, dispEn, hostWe, scanBusy;
    logic [7:0]           vDump;
    logic [`OBJ_AW-1:0]   hostAddr;
    objPkg::objAttr_t     hostData;
    logic [`PXL_DW-1:0]   objPxl;

    objPkg::objAttr_t     shadow [0:`OBJ_COUNT-1];   // what the host has written
    logic [`OBJ_AW-1:0]   wrAddrQ [$];
    objPkg::objAttr_t     wrDataQ [$];
    logic [`PXL_DW-1:0]   expCur  [0:255];            // line on screen now
    logic [`PXL_DW-1:0]   expNext [0:255];            // line drawn in this blank
    logic                 flipShown, flipNext;
    logic [31:0]          lcgState = 32'd70;
    int mismatchCount = 0;
    int dispErrCount  = 0;
    int otherCount    = 0;
    int cycleCount    = 0;

    objSystem objSystem_inst (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxlCen   ( pxlCen   ),
        .lhbl     ( lhbl     ),
        .vDump    ( vDump    ),
        .flip     ( flip     ),
        .dispEn   ( dispEn   ),
        .hostWe   ( hostWe   ),
        .hostAddr ( hostAddr ),
        .hostData ( hostData ),
        .objPxl   ( objPxl   ),
        .scanBusy ( scanBusy )
    );

    initial begin
        forever #10 clk = ~clk;    // 20 ns period
    end

    // display off must always give blank
    assert property (@(posedge clk) disable iff (rst) !dispEn |-> objPxl == blank)
        else begin
            dispErrCount++;
            $display("Mismatch at %0t: objPxl = %h, expected %h (display off)",
                     $time, objPxl, blank);
        end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run went past %0d clock cycles", cycleLimit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [15:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];
    endfunction

    function automatic objPkg::objAttr_t makeAttr(input logic [8:0] x, input logic [7:0] y,
                                                  input logic [3:0] c, input logic [3:0] w);
        objPkg::objAttr_t a;
        a.raw          = '0;
        a.fields.posX  = x;
        a.fields.posY  = y;
        a.fields.colour = c;
        a.fields.width = w;
        return a;
    endfunction

    // one pxlCen period with queued host writes going out one per clk
    task automatic pxlTick(input logic lhblV);
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            pxlCen = (c == 0);
            lhbl   = lhblV;
            if (wrAddrQ.size() > 0) begin
                hostWe   = 1'b1;
                hostAddr = wrAddrQ.pop_front();
                hostData = wrDataQ.pop_front();
            end else begin
                hostWe = 1'b0;
            end
        end
    endtask

    task automatic queueWrite(input logic [`OBJ_AW-1:0] slot, input objPkg::objAttr_t a);
        wrAddrQ.push_back(slot);
        wrDataQ.push_back(a);
        shadow[slot] = a;   // model sees it at once
    endtask

    // all ones parks every slot off screen and transparent
    task automatic parkAll();
        for (int s = 0; s < `OBJ_COUNT; s++) begin
            queueWrite(`OBJ_AW'(s), '1);
        end
    endtask

    // every slot lands on target and the line after it
    task automatic randomObjects(input logic [7:0] target);
        logic [15:0] r;
        logic [15:0] q;
        for (int s = 0; s < `OBJ_COUNT; s++) begin
            r = nextRand();
            q = nextRand();
            queueWrite(`OBJ_AW'(s), makeAttr({1'b0, r[7:0]}, target - 8'(q % 16'd15),
                                             r[11:8], r[15:12]));
        end
    endtask

    // x clipping and parking plus a transparent object over a visible one
    task automatic clipObjects(input logic [7:0] target);
        for (int s = 0; s < `OBJ_COUNT; s++) begin
            queueWrite(`OBJ_AW'(s), makeAttr(9'h1ff, 8'hff, 4'hf, 4'hf));
        end
        queueWrite(4'd0, makeAttr(9'd300, target, 4'd3, 4'd15));        // parked
        queueWrite(4'd1, makeAttr(9'd250, target, 4'd5, 4'd15));        // crosses 256
        queueWrite(4'd2, makeAttr(9'd256, target - 8'd4, 4'd7, 4'd15)); // just off screen
        queueWrite(4'd3, makeAttr(9'd100, target, 4'd15, 4'd7));        // see-through
        queueWrite(4'd4, makeAttr(9'd96, target - 8'd3, 4'd9, 4'd15));
    endtask

    // reference line built from slot 15 down to 0 so lower slots land last
    task automatic buildLine(input logic [7:0] lineNo);
        logic [7:0] dy;
        logic [9:0] x;
        for (int c = 0; c < 256; c++) expNext[c] = blank;
        for (int s = `OBJ_COUNT - 1; s >= 0; s--) begin
            dy = lineNo - shadow[s].fields.posY;
            if (dy < 8'(`OBJ_WIDTH) && shadow[s].fields.colour != blank) begin
                for (int i = 0; i <= int'(shadow[s].fields.width); i++) begin
                    x = 10'(shadow[s].fields.posX) + 10'(i);
                    if (x < 10'd256) expNext[x[7:0]] = shadow[s].fields.colour;
                end
            end
        end
    endtask

    // controls and writes for the scan in this line's blank
    task automatic setupLine(input int line);
        case (line)
            0: parkAll();               // no objects for line 1
            1: randomObjects(8'd2);
            2: begin
                flip = 1'b1;            // line 3 drawn mirrored
                randomObjects(8'd3);
            end
            3: begin
                flip = 1'b0;
                clipObjects(8'd4);
            end
            4: randomObjects(8'd5);
            6: parkAll();
            7: randomObjects(8'd8);
            8: dispEn = 1'b0;
            9: dispEn = 1'b1;
            default: ;
        endcase
    endtask

    initial begin
        logic [7:0]         col;
        logic [`PXL_DW-1:0] expPxl;
        rst = 1'b1;
        pxlCen = 1'b0;
        lhbl = 1'b0;
        vDump = 8'd0;
        flip = 1'b0;
        dispEn = 1'b1;
        hostWe = 1'b0;
        hostAddr = '0;
        hostData = '0;
        flipShown = 1'b0;
        flipNext = 1'b0;
        for (int c = 0; c < 256; c++) expCur[c] = blank;
        pxlTick(1'b0);
        pxlTick(1'b0);      // 8 clk of reset
        rst = 1'b0;

        for (int line = 0; line < numLines; line++) begin
            vDump = 8'(line);
            setupLine(line);
            for (int k = 0; k < activeTicks; k++) begin
                pxlTick(1'b1);
                col    = flipShown ? 8'(255 - k) : 8'(k);
                expPxl = dispEn ? expCur[col] : blank;
                assert (objPxl === expPxl) else begin
                    mismatchCount++;
                    $display("Mismatch at %0t: objPxl = %h, expected %h (line %0d column %0d)",
                             $time, objPxl, expPxl, line, k);
                end
            end
            buildLine(8'(line + 1));    // attributes as the scan finds them
            flipNext = flip;
            for (int t = 0; t < blankTicks; t++) begin
                if (line == 4 && t == 40) begin    // slots 15 and 14 already read
                    assert (scanBusy) else begin
                        otherCount++;
                        $display("scanner finished before the mid-blank writes on line %0d", line);
                    end
                    queueWrite(4'd15, makeAttr(9'd20, 8'd5, 4'd2, 4'd15));
                    queueWrite(4'd14, makeAttr(9'd30, 8'd6, 4'd4, 4'd9));
                end
                pxlTick(1'b0);
            end
            assert (!scanBusy) else begin
                otherCount++;
                $display("scanner still busy at the end of the blank after line %0d", line);
            end
            expCur    = expNext;
            flipShown = flipNext;
        end

        $display("checks done: %0d mismatches, %0d display-off mismatches, %0d other errors",
                 mismatchCount, dispErrCount, otherCount);
        if (mismatchCount + dispErrCount + otherCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
